//--- compile.f
+incdir+src
src/mmio_pkg.sv
src/mmio_decoder.sv
src/mem_bridge.sv
src/ext_reg_bank.sv
src/tft_write_port.sv
src/mmio_top.sv
test/mmio_checker.sv
test/tb_mmio.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_mmio -o sim_mmio

out="$(./obj_dir/sim_mmio)"
echo "$out"

if grep -qx "Simulation passed" <<< "$out"; then
    exit 0
fi
exit 1

//--- src/ext_reg_bank.sv
`include "mmio_consts.svh"

module ext_reg_bank (
    input  logic               clk,
    input  logic               rst,
    input  logic               reg_rd,    // cpu read request from the decoder
    input  mmio_pkg::reg_idx_t reg_addr,  // register picked by the cpu
    input  logic               load_en,   // outside load strobe
    input  mmio_pkg::reg_idx_t load_addr, // register to load
    input  mmio_pkg::word_t    load_data, // value to load
    output mmio_pkg::word_t    reg_rdata, // read data toward the decoder
    output logic               reg_busy   // read in progress
);

    localparam int WAIT = `REG_WAIT;
    localparam int CW   = $clog2(WAIT + 1);

    mmio_pkg::word_t regs [32];
    logic [CW-1:0]   wait_cnt; // cycles seen for the current read
    logic            done;     // read served, waiting for it to drop
    logic            fire;

    assign fire     = reg_rd && !done && (wait_cnt == CW'(WAIT));
    assign reg_busy = reg_rd && !done && !fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else if (!reg_rd) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else if (fire) begin
            wait_cnt <= '0;
            done     <= 1'b1; // one completion per request
        end else if (!done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // registers cleared on reset, loaded only from the outside port
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (load_en) begin
            regs[load_addr] <= load_data;
        end
    end

    // read data follows the held index, zero when not reading
    assign reg_rdata = reg_rd ? regs[reg_addr] : '0;

endmodule

//--- src/mem_bridge.sv
`include "mmio_consts.svh"

module mem_bridge (
    input  logic            clk,
    input  logic            rst,
    input  mmio_pkg::rwi_t  mem_rwi,   // access code from the decoder
    input  mmio_pkg::word_t mem_addr,  // prefixed address from the decoder
    input  mmio_pkg::word_t mem_wdata, // write data from the decoder
    output mmio_pkg::word_t mem_rdata, // read data, valid while the read is held
    output logic            mem_busy   // wait states in progress
);

    localparam int WAIT  = `MEM_WAIT;
    localparam int CW    = $clog2(WAIT + 1);
    localparam int AW    = `MEM_ADDR_BITS;
    localparam int WORDS = 1 << AW;

    mmio_pkg::word_t mem [WORDS];   // external memory model
    logic [AW-1:0]   mem_idx;
    logic [CW-1:0]   wait_cnt;      // cycles seen for the current request
    logic            done;          // request served, waiting for it to drop
    logic            req;
    logic            fire;          // completion cycle
    logic            is_write;

    assign req      = mem_rwi != mmio_pkg::RWI_IDLE;
    assign is_write = mem_rwi == mmio_pkg::RWI_WRITE;
    assign mem_idx  = mem_addr[AW-1:0]; // prefix byte ignored by the model
    assign fire     = req && !done && (wait_cnt == CW'(WAIT));
    assign mem_busy = req && !done && !fire; // high from the first cycle seen

    // power-up contents of the external memory
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = mmio_pkg::word_t'(i) ^ `MEM_INIT_XOR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else if (!req) begin
            wait_cnt <= '0; // request gone, ready for the next one
            done     <= 1'b0;
        end else if (fire) begin
            wait_cnt <= '0;
            done     <= 1'b1; // ignore the held request from here on
        end else if (!done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // write lands once, on the cycle busy drops
    always_ff @(posedge clk) begin
        if (!rst && fire && is_write) begin
            mem[mem_idx] <= mem_wdata;
        end
    end

    // combinational read, zero while writing or idle
    assign mem_rdata = (req && !is_write) ? mem[mem_idx] : '0;

endmodule

//--- src/mmio_consts.svh
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// inclusive upper bounds of each address region
`define MMIO_FETCH_MAX 32'd1024 // instruction fetch region
`define MMIO_REG_MAX   32'd1056 // external register region
`define MMIO_MEM_MAX   32'd1792 // data memory region
`define MMIO_TFT_MAX   32'd2047 // display write region

// top byte put in front of every memory address
`define MMIO_MEM_PREFIX 8'h33

// busy cycles each target holds per access
`define MEM_WAIT 3
`define REG_WAIT 1
`define TFT_WAIT 2

// memory model geometry and power-up pattern
`define MEM_ADDR_BITS 11           // 2048 words
`define MEM_INIT_XOR  32'hA5A50000 // word i holds i ^ this

`endif

//--- src/mmio_decoder.sv
`include "mmio_consts.svh"

module mmio_decoder (
    input  mmio_pkg::word_t    cpu_addr,    // access address from the memory handler
    input  mmio_pkg::rwi_t     cpu_rwi,     // access code from the memory handler
    input  mmio_pkg::word_t    cpu_wdata,   // write data from the memory handler
    input  mmio_pkg::word_t    mem_rdata,   // read data from the memory bridge
    input  logic               mem_busy,    // memory bridge working
    input  mmio_pkg::word_t    reg_rdata,   // read data from the register bank
    input  logic               reg_busy,    // register bank working
    input  logic               tft_busy,    // display port working
    output logic               busy,        // back to the memory handler
    output mmio_pkg::word_t    ext_data,    // data and register read result
    output mmio_pkg::word_t    instruction, // fetched instruction word
    output mmio_pkg::rwi_t     mem_rwi,     // access code toward memory
    output mmio_pkg::word_t    mem_addr,    // prefixed memory address
    output mmio_pkg::word_t    mem_wdata,   // memory write data
    output logic               reg_rd,      // register read request
    output mmio_pkg::reg_idx_t reg_addr,    // register index
    output logic               tft_wr,      // display write request
    output mmio_pkg::word_t    tft_addr,    // display write address
    output mmio_pkg::word_t    tft_wdata    // display write data
);

    logic            in_fetch; // 0 .. 1024
    logic            in_reg;   // 1025 .. 1056
    logic            in_mem;   // 1057 .. 1792
    logic            in_tft;   // 1793 .. 2047
    logic            is_write;
    logic            is_rd_data;
    logic            is_fetch;
    mmio_pkg::word_t mem_word_addr;

    assign in_fetch = cpu_addr <= `MMIO_FETCH_MAX;
    assign in_reg   = (cpu_addr > `MMIO_FETCH_MAX) && (cpu_addr <= `MMIO_REG_MAX);
    assign in_mem   = (cpu_addr > `MMIO_REG_MAX) && (cpu_addr <= `MMIO_MEM_MAX);
    assign in_tft   = (cpu_addr > `MMIO_MEM_MAX) && (cpu_addr <= `MMIO_TFT_MAX);

    assign is_write   = cpu_rwi == mmio_pkg::RWI_WRITE;
    assign is_rd_data = cpu_rwi == mmio_pkg::RWI_READ_DATA;
    // the handler may fetch with either read code, both land on the fetch path
    assign is_fetch   = (cpu_rwi == mmio_pkg::RWI_READ_INSTR) || is_rd_data;

    // memory region prefix in the top byte, lower 24 bits kept
    assign mem_word_addr = {`MMIO_MEM_PREFIX, cpu_addr[23:0]};

    always_comb begin
        busy        = 1'b0;                 // unrouted access never stalls
        ext_data    = '0;
        instruction = '0;
        mem_rwi     = mmio_pkg::RWI_IDLE;   // memory idle by default
        mem_addr    = '0;
        mem_wdata   = '0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        tft_wr      = 1'b0;
        tft_addr    = '0;
        tft_wdata   = '0;

        if (in_fetch && is_fetch) begin
            busy        = mem_busy;
            mem_rwi     = mmio_pkg::RWI_READ_INSTR; // fetch from instruction memory
            mem_addr    = mem_word_addr;
            instruction = mem_rdata;                 // ext_data stays zero
        end else if (in_reg && is_rd_data) begin
            busy     = reg_busy;
            reg_rd   = 1'b1;
            reg_addr = cpu_addr[4:0];                // low 5 bits pick the register
            ext_data = reg_rdata;
        end else if (in_mem && (is_write || is_rd_data)) begin
            busy     = mem_busy;
            mem_rwi  = cpu_rwi;                      // write or data read
            mem_addr = mem_word_addr;
            if (is_write) begin
                mem_wdata = cpu_wdata;
            end else begin
                ext_data = mem_rdata;
            end
        end else if (in_tft && is_write) begin
            busy      = tft_busy;
            tft_wr    = 1'b1;
            tft_addr  = cpu_addr;                    // display sees the raw address
            tft_wdata = cpu_wdata;
        end
    end

endmodule

//--- src/mmio_pkg.sv
package mmio_pkg;

    // access codes from the cpu memory handler, also used toward the memory
    typedef enum logic [1:0] {
        RWI_READ_INSTR = 2'b00, // instruction fetch
        RWI_WRITE      = 2'b01, // write to a target
        RWI_READ_DATA  = 2'b10, // data or register read
        RWI_IDLE       = 2'b11  // no access
    } rwi_t;

    // cpu data and address word
    typedef logic [31:0] word_t;

    // index into the external register bank
    typedef logic [4:0] reg_idx_t;

endpackage

//--- src/mmio_top.sv
module mmio_top (
    input  logic               clk,
    input  logic               rst,
    input  mmio_pkg::word_t    cpu_addr,    // memory handler address
    input  mmio_pkg::rwi_t     cpu_rwi,     // memory handler access code
    input  mmio_pkg::word_t    cpu_wdata,   // memory handler write data
    output logic               busy,        // stall back to the handler
    output mmio_pkg::word_t    ext_data,    // data and register reads
    output mmio_pkg::word_t    instruction, // fetched word
    input  logic               load_en,     // register bank load port
    input  mmio_pkg::reg_idx_t load_addr,
    input  mmio_pkg::word_t    load_data,
    output logic               disp_valid,  // display write strobe
    output mmio_pkg::word_t    disp_addr,
    output mmio_pkg::word_t    disp_data
);

    mmio_pkg::rwi_t     mem_rwi;
    mmio_pkg::word_t    mem_addr;
    mmio_pkg::word_t    mem_wdata;
    mmio_pkg::word_t    mem_rdata;
    logic               mem_busy;
    logic               reg_rd;
    mmio_pkg::reg_idx_t reg_addr;
    mmio_pkg::word_t    reg_rdata;
    logic               reg_busy;
    logic               tft_wr;
    mmio_pkg::word_t    tft_addr;
    mmio_pkg::word_t    tft_wdata;
    logic               tft_busy;

    mmio_decoder u_decoder (
        .cpu_addr, .cpu_rwi, .cpu_wdata,
        .mem_rdata, .mem_busy, .reg_rdata, .reg_busy, .tft_busy,
        .busy, .ext_data, .instruction,
        .mem_rwi, .mem_addr, .mem_wdata,
        .reg_rd, .reg_addr,
        .tft_wr, .tft_addr, .tft_wdata
    );

    mem_bridge u_mem (
        .clk, .rst,
        .mem_rwi, .mem_addr, .mem_wdata,
        .mem_rdata, .mem_busy
    );

    ext_reg_bank u_regs (
        .clk, .rst,
        .reg_rd, .reg_addr,
        .load_en, .load_addr, .load_data,
        .reg_rdata, .reg_busy
    );

    tft_write_port u_tft (
        .clk, .rst,
        .tft_wr, .tft_addr, .tft_wdata,
        .tft_busy, .disp_valid, .disp_addr, .disp_data
    );

endmodule

//--- src/tft_write_port.sv
`include "mmio_consts.svh"

module tft_write_port (
    input  logic            clk,
    input  logic            rst,
    input  logic            tft_wr,     // write request from the decoder
    input  mmio_pkg::word_t tft_addr,   // display write address
    input  mmio_pkg::word_t tft_wdata,  // display write data
    output logic            tft_busy,   // write still pacing
    output logic            disp_valid, // one-cycle strobe per accepted write
    output mmio_pkg::word_t disp_addr,  // address presented to the display
    output mmio_pkg::word_t disp_data   // data presented to the display
);

    localparam int WAIT = `TFT_WAIT;
    localparam int CW   = $clog2(WAIT + 1);

    logic [CW-1:0] wait_cnt; // cycles seen for the current write
    logic          done;     // write delivered, waiting for it to drop
    logic          fire;

    assign fire     = tft_wr && !done && (wait_cnt == CW'(WAIT));
    assign tft_busy = tft_wr && !done && !fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else if (!tft_wr) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else if (fire) begin
            wait_cnt <= '0;
            done     <= 1'b1;
        end else if (!done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // capture the held write during pacing, stable by the completion cycle
    always_ff @(posedge clk) begin
        if (tft_wr && !done) begin
            disp_addr <= tft_addr;
            disp_data <= tft_wdata;
        end
    end

    // strobe on the cycle busy drops, exactly once per write
    assign disp_valid = fire;

endmodule

//--- test/mmio_checker.sv
`include "mmio_consts.svh"

module mmio_checker (
    input  logic               clk,
    input  logic               rst,
    input  mmio_pkg::word_t    cpu_addr,      // watched cpu side of the dut
    input  mmio_pkg::rwi_t     cpu_rwi,
    input  mmio_pkg::word_t    cpu_wdata,
    input  logic               busy,
    input  mmio_pkg::word_t    ext_data,
    input  mmio_pkg::word_t    instruction,
    input  logic               load_en,       // watched register load port
    input  mmio_pkg::reg_idx_t load_addr,
    input  mmio_pkg::word_t    load_data,
    input  logic               disp_valid,    // watched display port
    input  mmio_pkg::word_t    disp_addr,
    input  mmio_pkg::word_t    disp_data,
    output int                 done_count,    // completed accesses seen
    output int                 data_errors,
    output int                 timing_errors
);

    localparam int AW    = `MEM_ADDR_BITS;
    localparam int WORDS = 1 << AW;

    // where an access ends up
    localparam int K_NONE   = 0;
    localparam int K_FETCH  = 1;
    localparam int K_REG    = 2;
    localparam int K_MEM_RD = 3;
    localparam int K_MEM_WR = 4;
    localparam int K_TFT    = 5;

    mmio_pkg::word_t shadow_mem [WORDS]; // expected memory contents
    mmio_pkg::word_t shadow_reg [32];    // expected register bank
    int              busy_cycles;        // busy seen for the current request
    logic            served;             // current request already completed
    mmio_pkg::word_t held_ext;           // read data expected while a served request stays
    mmio_pkg::word_t held_ins;
    int              n_done   = 0;
    int              n_data   = 0;
    int              n_timing = 0;

    assign done_count    = n_done;
    assign data_errors   = n_data;
    assign timing_errors = n_timing;

    // memory powers up with word i = i ^ init pattern
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            shadow_mem[AW'(i)] = mmio_pkg::word_t'(i) ^ `MEM_INIT_XOR;
        end
    end

    // fetch takes any read, registers only data reads
    function automatic int route(mmio_pkg::word_t addr, mmio_pkg::rwi_t rwi);
        logic rd;
        rd = (rwi == mmio_pkg::RWI_READ_INSTR) || (rwi == mmio_pkg::RWI_READ_DATA);
        if (addr <= `MMIO_FETCH_MAX) return rd ? K_FETCH : K_NONE;
        if (addr <= `MMIO_REG_MAX) return (rwi == mmio_pkg::RWI_READ_DATA) ? K_REG : K_NONE;
        if (addr <= `MMIO_MEM_MAX) begin
            if (rwi == mmio_pkg::RWI_WRITE) return K_MEM_WR;
            return (rwi == mmio_pkg::RWI_READ_DATA) ? K_MEM_RD : K_NONE;
        end
        if (addr <= `MMIO_TFT_MAX) return (rwi == mmio_pkg::RWI_WRITE) ? K_TFT : K_NONE;
        return K_NONE; // above 2047
    endfunction

    function automatic int latency(int kind);
        case (kind)
            K_FETCH, K_MEM_RD, K_MEM_WR: return `MEM_WAIT;
            K_REG:                       return `REG_WAIT;
            K_TFT:                       return `TFT_WAIT;
            default:                     return 0; // unmapped never stalls
        endcase
    endfunction

    task automatic compare_word(string name, mmio_pkg::word_t want, mmio_pkg::word_t got);
        if (got !== want) begin
            n_data++;
            $display("error %s expected %h got %h (addr %h rwi %h)",
                     name, want, got, cpu_addr, cpu_rwi);
        end
    endtask

    // one call per request, on the cycle busy is low
    task automatic check_completion();
        int              kind;
        int              want_lat;
        mmio_pkg::word_t mem_a;
        mmio_pkg::word_t want_ext;
        mmio_pkg::word_t want_ins;
        logic [AW-1:0]   idx;
        logic            want_valid;
        kind       = route(cpu_addr, cpu_rwi);
        mem_a      = {`MMIO_MEM_PREFIX, cpu_addr[23:0]}; // prefixed memory address
        idx        = mem_a[AW-1:0];                      // model keeps the low bits
        want_ext   = '0;
        want_ins   = '0;
        want_valid = kind == K_TFT;
        case (kind)
            K_FETCH:  want_ins = shadow_mem[idx];
            K_MEM_RD: want_ext = shadow_mem[idx];
            K_REG:    want_ext = shadow_reg[cpu_addr[4:0]];
            default:  ;
        endcase
        want_lat = latency(kind);
        if (busy_cycles != want_lat) begin
            n_timing++;
            $display("error busy_cycles expected %0h got %0h (addr %h rwi %h)",
                     want_lat, busy_cycles, cpu_addr, cpu_rwi);
        end
        compare_word("ext_data", want_ext, ext_data);
        compare_word("instruction", want_ins, instruction);
        if (disp_valid !== want_valid) begin
            n_data++;
            $display("error disp_valid expected %h got %h (addr %h)",
                     want_valid, disp_valid, cpu_addr);
        end
        if (want_valid) begin
            compare_word("disp_addr", cpu_addr, disp_addr);
            compare_word("disp_data", cpu_wdata, disp_data);
        end
        held_ext = want_ext; // read data stays while the request is held
        held_ins = want_ins;
        if (kind == K_MEM_WR) shadow_mem[idx] = cpu_wdata; // write lands now
    endtask

    // register shadow follows the load port like the bank does
    always @(posedge clk) begin
        if (rst) begin
            shadow_reg <= '{default: '0};
        end else if (load_en) begin
            shadow_reg[load_addr] <= load_data;
        end
    end

    // sample away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            busy_cycles = 0;
            served      = 1'b0;
        end else if (cpu_rwi == mmio_pkg::RWI_IDLE) begin
            busy_cycles = 0;
            served      = 1'b0;
            compare_word("ext_data", '0, ext_data); // idle must be quiet
            compare_word("instruction", '0, instruction);
            if (busy || disp_valid) begin
                n_timing++;
                $display("busy or display strobe active while the cpu is idle");
            end
        end else if (served) begin
            compare_word("ext_data", held_ext, ext_data);
            compare_word("instruction", held_ins, instruction);
            if (busy || disp_valid) begin
                n_timing++;
                $display("target restarted on a request it already served");
            end
        end else if (busy) begin
            busy_cycles++;
            if (disp_valid) begin
                n_data++;
                $display("error disp_valid expected 0 got 1 while busy (addr %h)", cpu_addr);
            end
        end else begin
            check_completion();
            served = 1'b1;
            n_done++;
        end
    end

endmodule

//--- test/tb_mmio.sv
`include "mmio_consts.svh"

module tb_mmio;

    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = `MEM_WAIT + 5; // longest access, completion, hold, idle
    localparam int MARGIN       = 50;

    typedef struct packed {
        mmio_pkg::rwi_t     rwi;
        mmio_pkg::word_t    addr;
        mmio_pkg::word_t    wdata;
        logic               ld_en;   // row also loads a register
        mmio_pkg::reg_idx_t ld_addr;
        mmio_pkg::word_t    ld_data;
        logic [1:0]         hold;    // extra cycles held after completion
    } row_t;

    logic               clk = 1'b0;
    logic               rst;
    mmio_pkg::word_t    cpu_addr;
    mmio_pkg::rwi_t     cpu_rwi;
    mmio_pkg::word_t    cpu_wdata;
    logic               busy;
    mmio_pkg::word_t    ext_data;
    mmio_pkg::word_t    instruction;
    logic               load_en;
    mmio_pkg::reg_idx_t load_addr;
    mmio_pkg::word_t    load_data;
    logic               disp_valid;
    mmio_pkg::word_t    disp_addr;
    mmio_pkg::word_t    disp_data;

    row_t   table_q[$];   // stimulus, applied in order
    integer seed = 41;
    int     done_count;
    int     data_errors;
    int     timing_errors;
    int     budget;

    always #5 clk = ~clk;

    mmio_top dut (
        .clk, .rst,
        .cpu_addr, .cpu_rwi, .cpu_wdata,
        .busy, .ext_data, .instruction,
        .load_en, .load_addr, .load_data,
        .disp_valid, .disp_addr, .disp_data
    );

    mmio_checker u_checker (
        .clk, .rst,
        .cpu_addr, .cpu_rwi, .cpu_wdata,
        .busy, .ext_data, .instruction,
        .load_en, .load_addr, .load_data,
        .disp_valid, .disp_addr, .disp_data,
        .done_count, .data_errors, .timing_errors
    );

    task automatic add_row(mmio_pkg::rwi_t rwi, mmio_pkg::word_t addr, mmio_pkg::word_t wdata,
                           logic ld_en, mmio_pkg::reg_idx_t ld_addr, mmio_pkg::word_t ld_data);
        row_t r;
        r.rwi     = rwi;
        r.addr    = addr;
        r.wdata   = wdata;
        r.ld_en   = ld_en;
        r.ld_addr = ld_addr;
        r.ld_data = ld_data;
        r.hold    = 2'd0;
        table_q.push_back(r);
    endtask

    task automatic add_access(mmio_pkg::rwi_t rwi, mmio_pkg::word_t addr, mmio_pkg::word_t wdata);
        add_row(rwi, addr, wdata, 1'b0, '0, '0);
    endtask

    // access that stays on the bus for a few cycles after it completes
    task automatic add_held(mmio_pkg::rwi_t rwi, mmio_pkg::word_t addr, mmio_pkg::word_t wdata,
                            logic [1:0] hold);
        row_t r;
        r       = '0;
        r.rwi   = rwi;
        r.addr  = addr;
        r.wdata = wdata;
        r.hold  = hold;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        add_access(mmio_pkg::RWI_READ_INSTR, 0, 0);                   // lowest fetch address
        add_access(mmio_pkg::RWI_READ_INSTR, 1024, 0);                // highest fetch address
        add_held(mmio_pkg::RWI_READ_INSTR, 517, 0, 2'd2);             // held past completion
        add_row(mmio_pkg::RWI_READ_DATA, 1025, 0, 1'b1, 5'd20, 32'h13579BDF); // reg 1 unloaded
        add_row(mmio_pkg::RWI_READ_DATA, 1030, 0, 1'b1, 5'd6, 32'hDEADBEEF);  // load then read
        add_row(mmio_pkg::RWI_READ_DATA, 1056, 0, 1'b1, 5'd0, 32'h12345678);
        add_held(mmio_pkg::RWI_READ_DATA, 1044, 0, 2'd1);             // reg 20 loaded above
        add_access(mmio_pkg::RWI_WRITE, 1057, $random(seed));         // data region bottom
        add_access(mmio_pkg::RWI_READ_DATA, 1057, 0);
        add_held(mmio_pkg::RWI_READ_DATA, 1300, 0, 2'd1);             // unwritten so init pattern
        add_access(mmio_pkg::RWI_WRITE, 1792, $random(seed));         // data region top
        add_access(mmio_pkg::RWI_READ_DATA, 1792, 0);
        add_held(mmio_pkg::RWI_WRITE, 1793, $random(seed), 2'd2);     // lowest display address
        add_access(mmio_pkg::RWI_WRITE, 2047, 32'hCAFEF00D);          // highest display address
        add_access(mmio_pkg::RWI_WRITE, 200, $random(seed));          // dropped in fetch region
        add_access(mmio_pkg::RWI_READ_INSTR, 200, 0);                 // must still be initial
        add_access(mmio_pkg::RWI_WRITE, 1040, $random(seed));         // dropped in reg region
        add_held(mmio_pkg::RWI_READ_DATA, 1800, 0, 2'd1);             // read above 1792
        add_access(mmio_pkg::RWI_READ_INSTR, 3000, 0);                // above 2047
        add_row(mmio_pkg::RWI_WRITE, 4096, $random(seed), 1'b1, 5'd9, 32'h0BADCAFE);
        add_access(mmio_pkg::RWI_READ_DATA, 1033, 0);                 // reg 9
        add_access(mmio_pkg::RWI_READ_DATA, 5000, 0);
        add_held(mmio_pkg::RWI_WRITE, 1500, $random(seed), 2'd1);
        add_access(mmio_pkg::RWI_READ_DATA, 1500, 0);
        add_access(mmio_pkg::RWI_READ_INSTR, 1100, 0);                // fetch code off its range
        add_access(mmio_pkg::RWI_READ_DATA, 1040, 0);                 // reg 16, never loaded
    endtask

    // hold the request until busy drops and for any extra cycles, then one idle cycle
    task automatic run_row(row_t r);
        @(posedge clk);
        cpu_rwi   <= r.rwi;
        cpu_addr  <= r.addr;
        cpu_wdata <= r.wdata;
        load_en   <= r.ld_en;
        load_addr <= r.ld_addr;
        load_data <= r.ld_data;
        @(negedge clk);
        while (busy) begin
            @(posedge clk);
            load_en <= 1'b0; // a load lasts one cycle
            @(negedge clk);
        end
        repeat (r.hold) @(posedge clk); // request stays on after it completes
        @(posedge clk);
        cpu_rwi <= mmio_pkg::RWI_IDLE;
        load_en <= 1'b0;
    endtask

    initial begin
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_rwi   = mmio_pkg::RWI_IDLE;
        cpu_wdata = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (table_q[i]) begin
            run_row(table_q[i]);
        end
        repeat (2) @(posedge clk); // let the checker see the last idle cycle
        @(negedge clk);
        if (done_count != table_q.size()) begin
            $display("only %0d of %0d accesses completed", done_count, table_q.size());
        end
        $display("accesses %0d, data errors %0d, timing errors %0d",
                 done_count, data_errors, timing_errors);
        if (data_errors == 0 && timing_errors == 0 && done_count == table_q.size()) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog budget scales with the table
    initial begin
        @(posedge clk); // table is built by now
        budget = table_q.size() * ROW_CYCLES + RESET_CYCLES + MARGIN;
        repeat (budget) @(posedge clk);
        $display("timeout: the accesses did not finish within %0d cycles", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule
